/* icache_pkg.sv */
package icache_pkg;

  localparam int XLEN      = 32;
  localparam int IDX_LEN   = 7;
  localparam int BLK_LEN   = 6;
  localparam int TAG_LEN   = XLEN - IDX_LEN - BLK_LEN;  // 19
  localparam int NUM_SETS  = 128;
  localparam int NUM_BANKS = 4;
  localparam int BANK_W    = 128;
  localparam int LANES     = BANK_W / XLEN;            // words per bank row
  localparam int BEATS     = 16;
  localparam int CNT_LEN   = $clog2(BEATS);
  localparam int LINE_LEN  = XLEN - BLK_LEN;           // line address width

  // fetch address split into cache fields
  typedef struct packed {
    logic [TAG_LEN-1:0] tag;
    logic [IDX_LEN-1:0] index;
    logic [BLK_LEN-1:0] blk;
  } icache_addr_fields_t;

  typedef union packed {
    logic [XLEN-1:0]     raw;
    icache_addr_fields_t fields;
  } icache_addr_u;

  typedef struct packed {
    logic         valid;
    icache_addr_u addr;
  } fetch_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] data;
  } fetch_resp_t;

  typedef struct packed {
    logic                valid;
    logic [LINE_LEN-1:0] line;  // addr[31:6]
  } mem_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] data;
  } mem_beat_t;

  // active-low strobes, as on the SRAM macro
  typedef struct packed {
    logic               cen_n;
    logic               wen_n;
    logic [IDX_LEN-1:0] addr;
    logic [BANK_W-1:0]  bwen_n;
    logic [BANK_W-1:0]  wdata;
  } sram_port_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    CHECK,
    MISS_REQ,
    REFILL,
    RESP
  } icache_state_e;

endpackage

/* sram_bank.sv */
`timescale 1ns/10ps

module sram_bank import icache_pkg::*; (
  input  logic              clk,
  input  sram_port_t        sram_i,
  output logic [BANK_W-1:0] rdata_o
);

  logic [BANK_W-1:0] mem [NUM_SETS];
  logic [BANK_W-1:0] wr_word;

  // merge new bits into the old row, mask low means write
  assign wr_word = (mem[sram_i.addr] & sram_i.bwen_n) | (sram_i.wdata & ~sram_i.bwen_n);

  always_ff @(posedge clk) begin
    if (!sram_i.cen_n) begin
      if (!sram_i.wen_n) begin
        mem[sram_i.addr] <= wr_word;
      end else begin
        rdata_o <= mem[sram_i.addr];  // holds until next read
      end
    end
  end

endmodule

/* icache_data.sv */
`timescale 1ns/10ps

module icache_data import icache_pkg::*; (
  input  logic               clk,
  input  logic [IDX_LEN-1:0] index_i,
  input  logic [BLK_LEN-1:0] blk_addr_i,
  input  logic [XLEN-1:0]    beat_data_i,
  input  logic [CNT_LEN-1:0] burst_count_i,
  input  logic               wen_i,
  input  logic               ren_i,
  output logic [XLEN-1:0]    rdata_o
);

  sram_port_t           bank_port  [NUM_BANKS];
  logic [BANK_W-1:0]    bank_rdata [NUM_BANKS];
  logic [NUM_BANKS-1:0] rd_sel;
  logic [NUM_BANKS-1:0] wr_sel;
  logic [NUM_BANKS-1:0] rd_sel_q;
  logic [BANK_W-1:0]    lane_mask;
  logic [BANK_W-1:0]    line_rd;

  // bank selects, read by block address, write by beat number
  always_comb begin
    rd_sel = '0;
    wr_sel = '0;
    rd_sel[blk_addr_i[5:4]]    = ren_i;
    wr_sel[burst_count_i[3:2]] = wen_i;
  end

  always_comb begin
    lane_mask = '0;
    lane_mask[burst_count_i[1:0]*XLEN +: XLEN] = '1;
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign bank_port[b].cen_n  = ~(rd_sel[b] | wr_sel[b]);
    assign bank_port[b].wen_n  = ~wr_sel[b];
    assign bank_port[b].addr   = index_i;
    assign bank_port[b].bwen_n = ~lane_mask;
    assign bank_port[b].wdata  = {LANES{beat_data_i}};  // beat copied to every lane

    sram_bank u_bank (
      .clk     (clk),
      .sram_i  (bank_port[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  // remember which bank was read so the output mux lines up with rdata
  always_ff @(posedge clk) begin
    if (ren_i) begin
      rd_sel_q <= rd_sel;
    end
  end

  always_comb begin
    line_rd = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      line_rd = line_rd | ({BANK_W{rd_sel_q[b]}} & bank_rdata[b]);
    end
  end

  assign rdata_o = line_rd[blk_addr_i[3:2]*XLEN +: XLEN];  // word within the row

endmodule

/* icache_tag.sv */
`timescale 1ns/10ps

module icache_tag import icache_pkg::*; (
  input  logic         clk,
  input  logic         rst_i,
  input  icache_addr_u addr_i,
  input  logic         fill_i,
  output logic         hit_o
);

  logic [TAG_LEN-1:0]  tag_mem [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;
  logic [IDX_LEN-1:0]  idx;
  logic                tag_eq;

  assign idx    = addr_i.fields.index;
  assign tag_eq = (tag_mem[idx] == addr_i.fields.tag);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i) begin
      tag_mem[idx] <= addr_i.fields.tag;
    end
  end

  // address is held by ctrl, so the value sampled at the end of
  // LOOKUP is what CHECK sees, same cycle as the bank data
  always_ff @(posedge clk) begin
    if (rst_i) begin
      hit_o <= 1'b0;
    end else begin
      hit_o <= valid_q[idx] && tag_eq;
    end
  end

endmodule

/* icache_burst_cnt.sv */
`timescale 1ns/10ps

module icache_burst_cnt import icache_pkg::*; (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               clear_i,
  input  logic               beat_i,
  output logic [CNT_LEN-1:0] count_o,
  output logic               last_o
);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      count_o <= '0;
    end else if (clear_i) begin
      count_o <= '0;
    end else if (beat_i) begin
      count_o <= count_o + 1'b1;  // wraps after the last beat
    end
  end

  assign last_o = beat_i && (count_o == CNT_LEN'(BEATS - 1));

endmodule

/* icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*; (
  input  logic         clk,
  input  logic         rst_i,
  input  fetch_req_t   req_i,
  input  logic         hit_i,
  input  logic         beat_valid_i,
  input  logic         last_beat_i,
  output icache_addr_u addr_o,
  output logic         rd_en_o,
  output logic         refill_we_o,
  output logic         cnt_clear_o,
  output logic         fill_o,
  output mem_req_t     mem_req_o,
  output logic         resp_valid_o
);

  icache_state_e state_q;
  icache_state_e state_d;
  icache_addr_u  addr_q;
  logic          accept;

  assign accept = (state_q == IDLE) && req_i.valid;  // dropped in any other state

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= req_i.addr;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i.valid) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        state_d = CHECK;  // banks and tag read this cycle
      end
      CHECK: begin
        if (hit_i) begin
          state_d = RESP;
        end else begin
          state_d = MISS_REQ;
        end
      end
      MISS_REQ: begin
        state_d = REFILL;
      end
      REFILL: begin
        // line is complete, look it up again
        if (beat_valid_i && last_beat_i) begin
          state_d = LOOKUP;
        end
      end
      RESP: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign addr_o       = addr_q;
  assign rd_en_o      = (state_q == LOOKUP);
  assign refill_we_o  = (state_q == REFILL) && beat_valid_i;
  assign cnt_clear_o  = (state_q == MISS_REQ);
  assign fill_o       = refill_we_o && last_beat_i;
  assign resp_valid_o = (state_q == RESP);

  // line request, whole line from its base
  assign mem_req_o.valid = (state_q == MISS_REQ);
  assign mem_req_o.line  = {addr_q.fields.tag, addr_q.fields.index};

endmodule

/* icache_top.sv */
`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,
  input  fetch_req_t  req_i,
  output fetch_resp_t resp_o,
  output mem_req_t    mem_req_o,
  input  mem_beat_t   beat_i
);

  icache_addr_u       addr;
  logic               hit;
  logic               rd_en;
  logic               refill_we;
  logic               cnt_clear;
  logic               fill;
  logic               resp_valid;
  logic [CNT_LEN-1:0] burst_count;
  logic               last_beat;
  logic [XLEN-1:0]    rdata;

  icache_ctrl u_ctrl (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .hit_i        (hit),
    .beat_valid_i (beat_i.valid),
    .last_beat_i  (last_beat),
    .addr_o       (addr),
    .rd_en_o      (rd_en),
    .refill_we_o  (refill_we),
    .cnt_clear_o  (cnt_clear),
    .fill_o       (fill),
    .mem_req_o    (mem_req_o),
    .resp_valid_o (resp_valid)
  );

  // counts only beats taken in REFILL
  icache_burst_cnt u_burst_cnt (
    .clk     (clk),
    .rst_i   (rst_i),
    .clear_i (cnt_clear),
    .beat_i  (refill_we),
    .count_o (burst_count),
    .last_o  (last_beat)
  );

  icache_tag u_tag (
    .clk    (clk),
    .rst_i  (rst_i),
    .addr_i (addr),
    .fill_i (fill),
    .hit_o  (hit)
  );

  icache_data u_data (
    .clk           (clk),
    .index_i       (addr.fields.index),
    .blk_addr_i    (addr.fields.blk),
    .beat_data_i   (beat_i.data),
    .burst_count_i (burst_count),
    .wen_i         (refill_we),
    .ren_i         (rd_en),
    .rdata_o       (rdata)
  );

  assign resp_o.valid = resp_valid;
  assign resp_o.data  = rdata;

endmodule

/* icache_assert.sv */
`timescale 1ns/10ps

module icache_assert import icache_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_i,
  input fetch_req_t           req_i,
  input fetch_resp_t          resp_i,
  input mem_req_t             mem_req_i,
  input icache_state_e        state_i,
  input logic [NUM_BANKS-1:0] bank_cen_n_i
);

  int fail_cnt = 0;  // failed assertions so far

  // RESP and MISS_REQ never overlap
  a_resp_mem_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(resp_i.valid && mem_req_i.valid))
    else begin
      fail_cnt++;
      $error("response and line request in the same cycle");
    end

  // slowest refill is about 60 cycles
  a_resp_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_i.valid && state_i == IDLE) |-> ##[2:100] resp_i.valid)
    else begin
      fail_cnt++;
      $error("no response within 100 cycles of a request");
    end

  a_one_bank: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(~bank_cen_n_i))
    else begin
      fail_cnt++;
      $error("more than one data bank enabled");
    end

  a_req_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.valid |-> state_i == IDLE)
    else begin
      fail_cnt++;
      $error("request sent while the cache is busy");
    end

endmodule

bind icache_top icache_assert u_assert (
  .clk_i        (clk),
  .rst_i        (rst_i),
  .req_i        (req_i),
  .resp_i       (resp_o),
  .mem_req_i    (mem_req_o),
  .state_i      (u_ctrl.state_q),
  .bank_cen_n_i ({u_data.bank_port[3].cen_n, u_data.bank_port[2].cen_n,
                  u_data.bank_port[1].cen_n, u_data.bank_port[0].cen_n})
);

/* tb_icache.sv */
`timescale 1ns/10ps

module tb_icache import icache_pkg::*; ();

  logic        clk;
  logic        rst;
  fetch_req_t  req;
  fetch_resp_t resp;
  mem_req_t    mem_req;
  mem_beat_t   beat;

  int          seed;
  int          line_requests;  // counted by the memory model
  int          exp_requests;   // what the tests expect

  icache_top UUT (
    .clk       (clk),
    .rst_i     (rst),
    .req_i     (req),
    .resp_o    (resp),
    .mem_req_o (mem_req),
    .beat_i    (beat)
  );

  always #10 clk = ~clk;

  // memory contents, word at byte address A
  function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] a);
    return {a[XLEN-1:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // bound checker failures end the run as well
  always @(negedge clk) begin
    if (UUT.u_assert.fail_cnt != 0) begin
      $display("assertion failure in the bound checker at time %0t", $time);
      $display("TESTS FAILED");
      $fatal(1, "assertion failure");
    end
  end

  // line refill from the base, random gaps
  always begin
    logic [LINE_LEN-1:0] line;
    int                  gap;
    @(negedge clk);
    if (mem_req.valid === 1'b1) begin
      line = mem_req.line;
      line_requests++;
      gap = $urandom_range(5, 2);
      repeat (gap) @(posedge clk);
      for (int b = 0; b < BEATS; b++) begin
        @(posedge clk);
        #2;
        beat.valid = 1'b1;
        beat.data  = word_at({line, 6'b0} + b * 4);
        gap = $urandom_range(2, 0);
        repeat (gap) begin
          @(posedge clk);
          #2;
          beat.valid = 1'b0;
        end
      end
      @(posedge clk);
      #2;
      beat.valid = 1'b0;
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
  endtask

  // one request, then wait for the response strobe
  task automatic fetch(input logic [XLEN-1:0] a, output logic [XLEN-1:0] data,
                       output int latency);
    @(posedge clk);
    #2;
    req.valid    = 1'b1;
    req.addr.raw = a;
    @(posedge clk);  // request edge
    #2;
    req.valid = 1'b0;
    latency   = 0;
    @(negedge clk);
    while (resp.valid !== 1'b1) begin
      if (latency >= 200) begin
        $display("timeout: no response for fetch address %h after 200 cycles", a);
        $display("TESTS FAILED");
        $fatal(1, "fetch timeout");
      end
      @(posedge clk);
      latency++;
      @(negedge clk);
    end
    data = resp.data;
  endtask

  task automatic fetch_and_check(input logic [XLEN-1:0] a, input bit miss);
    logic [XLEN-1:0] data;
    int              latency;
    if (miss) begin
      exp_requests++;
    end
    fetch(a, data, latency);
    check("resp_o.data", data, word_at(a));
    check("line_requests", line_requests, exp_requests);
    if (!miss) begin
      check("hit latency", latency, 2);
    end
  endtask

  task automatic cold_miss_refill();
    fetch_and_check(32'h0004_0048, 1'b1);
  endtask

  task automatic same_line_hit();
    fetch_and_check(32'h0004_004c, 1'b0);
    fetch_and_check(32'h0004_0040, 1'b0);
  endtask

  // all four banks, every lane
  task automatic whole_line_sweep();
    logic [XLEN-1:0] base;
    int              order [BEATS];
    int              j;
    int              tmp;
    base = 32'h0008_1380;
    fetch_and_check(base + 32'h24, 1'b1);
    for (int i = 0; i < BEATS; i++) begin
      order[i] = i;
    end
    for (int i = BEATS - 1; i > 0; i--) begin
      j        = $urandom_range(i, 0);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < BEATS; i++) begin
      fetch_and_check(base + order[i] * 4, 1'b0);
    end
  endtask

  task automatic conflict_evict();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = 32'h0010_0104;
    b = a + 32'h0000_2000;  // same index, next tag
    fetch_and_check(a, 1'b1);
    fetch_and_check(b, 1'b1);
    fetch_and_check(a, 1'b1);
    fetch_and_check(a + 32'h38, 1'b0);
  endtask

  task automatic reset_invalidate();
    fetch_and_check(32'h0010_0104, 1'b0);
    apply_reset();
    fetch_and_check(32'h0010_0104, 1'b1);
  endtask

  // one tag per index, like the cache
  task automatic random_window_sweep();
    icache_addr_u        a;
    logic [TAG_LEN-1:0]  tag_model [NUM_SETS];
    logic [NUM_SETS-1:0] valid_model;
    logic [IDX_LEN-1:0]  idx;
    bit                  miss;
    valid_model = '0;  // sets 40..43 untouched since reset
    for (int n = 0; n < 40; n++) begin
      a.fields.tag   = TAG_LEN'(32'h40 + $urandom_range(2, 0));
      a.fields.index = IDX_LEN'(40 + $urandom_range(3, 0));
      a.fields.blk   = {4'($urandom_range(15, 0)), 2'b00};
      idx  = a.fields.index;
      miss = !(valid_model[idx] && tag_model[idx] == a.fields.tag);
      valid_model[idx] = 1'b1;
      tag_model[idx]   = a.fields.tag;
      fetch_and_check(a.raw, miss);
    end
  endtask

  initial begin
    seed = 54603;
    void'($urandom(seed));
    clk           = 1'b0;
    rst           = 1'b1;
    req           = '0;
    beat          = '0;
    line_requests = 0;
    exp_requests  = 0;
    apply_reset();

    cold_miss_refill();
    same_line_hit();
    whole_line_sweep();
    conflict_evict();
    reset_invalidate();
    random_window_sweep();

    repeat (2) @(posedge clk);
    check("final line_requests", line_requests, exp_requests);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* files.f */
icache_pkg.sv
sram_bank.sv
icache_data.sv
icache_tag.sv
icache_burst_cnt.sv
icache_ctrl.sv
icache_top.sv
icache_assert.sv
tb_icache.sv
